//--- dv/soundFxChecks.svh
`ifndef SOUND_FX_CHECKS_SVH
`define SOUND_FX_CHECKS_SVH

// Mismatches seen so far
int errorCount = 0;

////////////////////////////////////////////////////////////////////////////
// Error exit
////////////////////////////////////////////////////////////////////////////

task automatic reportError(input string msg);
  errorCount++;
  $display("ERR @%0t ns: %s", $time, msg);
  $display("STATUS: FAIL");
  $fatal(1, "first mismatch, run ended");
endtask

////////////////////////////////////////////////////////////////////////////
// Typed compares
////////////////////////////////////////////////////////////////////////////

// Note index
task automatic checkIndex(input string what, input noteIdxT got, input noteIdxT exp);
  if (got !== exp) begin
    reportError($sformatf("%s: noteIndex %0d, expected %0d", what, got, exp));
  end
endtask

// Duration code from the song bank
task automatic checkDuration(input string what, input durationT got, input durationT exp);
  if (got !== exp) begin
    reportError($sformatf("%s: duration %s (%0d), expected %s", what, got.name(), got,
                          exp.name()));
  end
endtask

// Counted cycles or pulses
task automatic checkCycles(input string what, input int got, input int exp);
  if (got != exp) begin
    reportError($sformatf("%s: counted %0d, expected %0d", what, got, exp));
  end
endtask

// Single-bit outputs
task automatic checkLevel(input string what, input logic got, input logic exp);
  if (got !== exp) begin
    reportError($sformatf("%s: level %b, expected %b", what, got, exp));
  end
endtask

`endif

//--- dv/soundFxPlayerTb.sv
`timescale 1ns/1ns

module soundFxPlayerTb import soundFxPkg::*; ();

  localparam int unitTicks = 64;
  localparam int toneShift = 10;
  localparam int clkPeriod = 20;

  // Pitches of the melody, ticks at 100 MHz
  localparam halfPeriodT pD5   = 18'd85131;
  localparam halfPeriodT pCs5  = 18'd90192;
  localparam halfPeriodT pC5   = 18'd95557;
  localparam halfPeriodT pB4   = 18'd101239;
  localparam halfPeriodT pAs4  = 18'd107259;
  localparam halfPeriodT pA4   = 18'd113636;
  localparam halfPeriodT pGs4  = 18'd120395;
  localparam halfPeriodT pG4   = 18'd127551;
  localparam halfPeriodT pF4   = 18'd143172;
  localparam halfPeriodT pE4   = 18'd151685;
  localparam halfPeriodT pD4   = 18'd170265;
  localparam halfPeriodT pRest = 18'd0;

  logic     clk = 1'b0;
  logic     rstN;
  logic     start;
  logic     stop;
  logic     loop;
  logic     tone;
  logic     playing;
  noteIdxT  noteIndex;
  durationT duration;
  logic     songDone;

  integer seed = 99239;
  int     doneCount = 0;

  ////////////////////////////////////////////////////////////////////////////
  // Song expectation table, rows 1..43
  ////////////////////////////////////////////////////////////////////////////

  durationT songDur [1:43] = '{
    quarter, eighth, eighth, tripletEighth, tripletEighth, tripletEighth,
    eighth, eighth, eighth, sixteenth, sixteenth, eighth, eighth,
    tripletSixteenth, tripletSixteenth, tripletSixteenth, sixteenth, sixteenth,
    eighth, eighth, eighth, eighth,
    eighth, eighth, tripletEighth, tripletEighth, tripletEighth, eighth, eighth,
    sixteenth, sixteenth, sixteenth, sixteenth, eighth, eighth,
    tripletSixteenth, tripletSixteenth, tripletSixteenth, sixteenth, sixteenth,
    eighth, eighth, quarter
  };

  // Rests at 1, 22 and 32
  halfPeriodT songHalf [1:43] = '{
    pRest, pD5, pCs5, pC5, pC5, pC5,
    pB4, pAs4, pA4, pA4, pA4, pGs4, pG4,
    pF4, pG4, pF4, pE4, pF4,
    pG4, pF4, pE4, pRest,
    pD5, pCs5, pC5, pC5, pC5, pB4, pAs4,
    pA4, pA4, pRest, pA4, pG4, pF4,
    pE4, pF4, pE4, pD4, pE4,
    pF4, pE4, pD4
  };

  `include "soundFxChecks.svh"

  soundFxPlayer #(
    .unitTicks (unitTicks),
    .toneShift (toneShift)
  ) soundFxPlayer_inst (
    .clk       (clk),
    .rstN      (rstN),
    .start     (start),
    .stop      (stop),
    .loop      (loop),
    .tone      (tone),
    .playing   (playing),
    .noteIndex (noteIndex),
    .duration  (duration),
    .songDone  (songDone)
  );

  always #(clkPeriod / 2) clk = ~clk;

  // 1/48 units per duration code
  function automatic int noteUnits(input durationT d);
    case (d)
      quarter:          return 12;
      eighth:           return 6;
      tripletEighth:    return 4;
      sixteenth:        return 3;
      tripletSixteenth: return 2;
      default:          return 0;
    endcase
  endfunction

  // Outputs settle well before this point
  task automatic nextCycle();
    @(posedge clk);
    #2;
  endtask

  task automatic checkQuiet(input string what);
    checkIndex(what, noteIndex, '0);
    checkLevel({what, " playing"}, playing, 1'b0);
    checkLevel({what, " tone"}, tone, 1'b0);
    checkLevel({what, " songDone"}, songDone, 1'b0);
  endtask

  // One cycle of a note, cycle 0 is the load cycle
  task automatic checkNoteCycle(input noteIdxT idx, input int cycle, input logic doneFirst);
    int    eff;
    logic  expTone;
    string where;
    where = $sformatf("note %0d cycle %0d", idx, cycle);
    eff = int'(songHalf[idx] >> toneShift);
    if (eff == 0) begin
      expTone = 1'b0;
    end else begin
      expTone = ((cycle / eff) % 2) == 1;
    end
    checkIndex(where, noteIndex, idx);
    checkDuration(where, duration, songDur[idx]);
    checkLevel({where, " playing"}, playing, 1'b1);
    checkLevel({where, " tone"}, tone, expTone);
    checkLevel({where, " songDone"}, songDone, (cycle == 0) ? doneFirst : 1'b0);
  endtask

  task automatic walkNote(input noteIdxT idx, input logic doneFirst, input logic pokeStart);
    int cycles;
    int noteLen;
    cycles = 0;
    noteLen = noteUnits(songDur[idx]) * unitTicks;
    checkIndex("note start", noteIndex, idx);
    while (noteIndex == idx && cycles <= noteLen) begin
      checkNoteCycle(idx, cycles, doneFirst);
      // Start in mid-song must not restart the melody
      if (pokeStart && cycles == 5) begin
        start = 1'b1;
      end
      nextCycle();
      start = 1'b0;
      cycles++;
    end
    checkCycles($sformatf("length of note %0d", idx), cycles, noteLen);
  endtask

  task automatic stopInNote(input noteIdxT idx, input logic doneFirst);
    for (int c = 0; c <= 7; c++) begin
      checkNoteCycle(idx, c, doneFirst);
      if (c == 7) begin
        stop = 1'b1;
      end
      nextCycle();
    end
    stop = 1'b0;
    checkQuiet("after stop");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Monitors
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (rstN) begin
      if (!playing) begin
        checkLevel("tone while stopped", tone, 1'b0);
      end
      if (songDone) begin
        doneCount++;
      end
    end
  end

  // Two full passes, the stop lap and some slack
  initial begin : watchdog
    int passCycles;
    passCycles = 0;
    for (int i = 1; i <= songLength; i++) begin
      passCycles += noteUnits(songDur[i]) * unitTicks;
    end
    #((3 * passCycles + 1000) * clkPeriod);
    $display("simulation timed out");
    $display("STATUS: FAIL");
    $fatal(1, "watchdog expired");
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    noteIdxT stopNote;
    rstN  = 1'b0;
    start = 1'b0;
    stop  = 1'b0;
    loop  = 1'b0;

    // Reset for 3 cycles
    repeat (3) begin
      nextCycle();
      checkQuiet("in reset");
    end
    rstN = 1'b1;
    repeat (3) begin
      nextCycle();
      checkQuiet("after reset");
    end

    // First pass, loop low, a stray start at note 10
    start = 1'b1;
    nextCycle();
    start = 1'b0;
    for (int n = 1; n <= songLength; n++) begin
      walkNote(noteIdxT'(n), 1'b0, n == 10);
    end
    checkIndex("song end", noteIndex, '0);
    checkDuration("song end", duration, noDur);
    checkLevel("song end playing", playing, 1'b0);
    checkLevel("song end songDone", songDone, 1'b1);
    nextCycle();
    checkQuiet("back in idle");
    checkCycles("songDone pulses after pass 1", doneCount, 1);
    repeat (10) begin
      nextCycle();
      checkQuiet("idle after song");
    end

    // Looping pass, wraps to note 1 and stops at a random note
    stopNote = noteIdxT'(1 + ($unsigned($random(seed)) % songLength));
    $display("stop test at note %0d", stopNote);
    loop  = 1'b1;
    start = 1'b1;
    nextCycle();
    start = 1'b0;
    for (int n = 1; n <= songLength; n++) begin
      walkNote(noteIdxT'(n), 1'b0, 1'b0);
    end
    for (int n = 1; n < stopNote; n++) begin
      walkNote(noteIdxT'(n), n == 1, 1'b0);
    end
    stopInNote(stopNote, stopNote == 1);
    repeat (20) begin
      nextCycle();
      checkQuiet("idle after stop");
    end
    checkCycles("songDone pulses after loop", doneCount, 2);
    loop = 1'b0;

    if (errorCount == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- soundFxPlayer.f
+incdir+dv
source/soundFxPkg.sv
source/songRom.sv
source/noteSequencer.sv
source/durationTimer.sv
source/toneGenerator.sv
source/soundFxPlayer.sv
dv/soundFxPlayerTb.sv

//--- source/durationTimer.sv
`timescale 1ns/1ns

module durationTimer import soundFxPkg::*; #(
  parameter int unitTicks = 104166
) (
  input  logic     clk,
  input  logic     rstN,
  input  logic     noteLoad,
  input  durationT duration,
  output logic     noteEnd
);

  // Wide enough for 16 units of unitTicks
  localparam int tickW = $clog2(16 * unitTicks);

  logic [tickW-1:0] noteTicks;
  logic [tickW-1:0] lastTick;
  logic [tickW-1:0] count;
  logic             running;

  // Note length in clock ticks
  assign noteTicks = tickW'(durationUnits(duration)) * tickW'(unitTicks);
  assign lastTick  = noteTicks - 1'b1;

  ////////////////////////////////////////////////////////////////////////////
  // Down-counter
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      count   <= '0;
      running <= 1'b0;
    end else if (noteLoad) begin
      // Load cycle already counts as the first tick
      count   <= lastTick - 1'b1;
      running <= 1'b1;
    end else if (duration == noDur) begin
      // Index went to 0, song stopped or ended
      running <= 1'b0;
    end else if (running) begin
      if (count == '0) begin
        running <= 1'b0;
      end else begin
        count <= count - 1'b1;
      end
    end
  end

  // Last cycle of the note
  // silent as soon as the index leaves the song
  assign noteEnd = running && (count == '0) && (duration != noDur);

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // End strobe is a single pulse, timer idles until reloaded
  singleEndPulse: assert property (@(posedge clk) disable iff (!rstN)
    noteEnd |=> !noteEnd);

endmodule

//--- source/noteSequencer.sv
`timescale 1ns/1ns

module noteSequencer import soundFxPkg::*; (
  input  logic    clk,
  input  logic    rstN,
  input  logic    start,
  input  logic    stop,
  input  logic    loop,
  input  logic    noteEnd,
  output noteIdxT noteIndex,
  output logic    playing,
  output logic    noteLoad,
  output logic    songDone
);

  seqStateT state;

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state     <= idle;
      noteIndex <= '0;
      playing   <= 1'b0;
      noteLoad  <= 1'b0;
      songDone  <= 1'b0;
    end else begin
      // Strobes last a single cycle
      noteLoad <= 1'b0;
      songDone <= 1'b0;

      case (state)
        idle: begin
          // Kick off from the first note
          if (start) begin
            state     <= playNote;
            noteIndex <= 6'd1;
            playing   <= 1'b1;
            noteLoad  <= 1'b1;
          end
        end

        playNote: begin
          // Stop wins over a note ending in the same cycle
          if (stop) begin
            state     <= idle;
            noteIndex <= '0;
            playing   <= 1'b0;
          end else if (noteEnd) begin
            if (noteIndex == songLength) begin
              // Song complete, flag it either way
              songDone <= 1'b1;
              if (loop) begin
                noteIndex <= 6'd1;
                noteLoad  <= 1'b1;
              end else begin
                state     <= finish;
                noteIndex <= '0;
                playing   <= 1'b0;
              end
            end else begin
              // Next note in the bank
              noteIndex <= noteIndex + 1'b1;
              noteLoad  <= 1'b1;
            end
          end
        end

        // One cycle holding songDone, then back to rest
        finish: state <= idle;

        default: state <= idle;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Counter never runs past the bank
  indexInRange: assert property (@(posedge clk) disable iff (!rstN)
    noteIndex <= songLength);

  // Timer has to be quiet once the sequencer is back in idle
  noEndInIdle: assert property (@(posedge clk) disable iff (!rstN)
    state == idle |-> !noteEnd);

endmodule

//--- source/songRom.sv
`timescale 1ns/1ns

module songRom import soundFxPkg::*; (
  input  noteIdxT    noteIndex,
  output durationT   duration,
  output halfPeriodT halfPeriod
);

  ////////////////////////////////////////////////////////////////////////////
  // Pitch table
  ////////////////////////////////////////////////////////////////////////////

  // Half-periods at 100 MHz, ticks = 1e8 / (2 * freq)
  localparam halfPeriodT noteD5  = 18'd85131;
  localparam halfPeriodT noteCs5 = 18'd90192;
  localparam halfPeriodT noteC5  = 18'd95557;
  localparam halfPeriodT noteB4  = 18'd101239;
  localparam halfPeriodT noteAs4 = 18'd107259;
  localparam halfPeriodT noteA4  = 18'd113636;
  localparam halfPeriodT noteGs4 = 18'd120395;
  localparam halfPeriodT noteG4  = 18'd127551;
  localparam halfPeriodT noteF4  = 18'd143172;
  localparam halfPeriodT noteE4  = 18'd151685;
  localparam halfPeriodT noteD4  = 18'd170265;
  // Rest plays silence
  localparam halfPeriodT rest    = 18'd0;

  ////////////////////////////////////////////////////////////////////////////
  // Song bank
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // Idle index and anything past the end read as silence
    duration   = noDur;
    halfPeriod = rest;
    if (noteIndex <= songLength) begin
      case (noteIndex)
        // Opening phrase
        6'd1:  begin duration = quarter;          halfPeriod = rest;    end
        6'd2:  begin duration = eighth;           halfPeriod = noteD5;  end
        6'd3:  begin duration = eighth;           halfPeriod = noteCs5; end
        6'd4:  begin duration = tripletEighth;    halfPeriod = noteC5;  end
        6'd5:  begin duration = tripletEighth;    halfPeriod = noteC5;  end
        6'd6:  begin duration = tripletEighth;    halfPeriod = noteC5;  end
        6'd7:  begin duration = eighth;           halfPeriod = noteB4;  end
        6'd8:  begin duration = eighth;           halfPeriod = noteAs4; end
        6'd9:  begin duration = eighth;           halfPeriod = noteA4;  end
        6'd10: begin duration = sixteenth;        halfPeriod = noteA4;  end
        6'd11: begin duration = sixteenth;        halfPeriod = noteA4;  end
        6'd12: begin duration = eighth;           halfPeriod = noteGs4; end
        6'd13: begin duration = eighth;           halfPeriod = noteG4;  end
        6'd14: begin duration = tripletSixteenth; halfPeriod = noteF4;  end
        6'd15: begin duration = tripletSixteenth; halfPeriod = noteG4;  end
        6'd16: begin duration = tripletSixteenth; halfPeriod = noteF4;  end
        6'd17: begin duration = sixteenth;        halfPeriod = noteE4;  end
        6'd18: begin duration = sixteenth;        halfPeriod = noteF4;  end
        6'd19: begin duration = eighth;           halfPeriod = noteG4;  end
        6'd20: begin duration = eighth;           halfPeriod = noteF4;  end
        6'd21: begin duration = eighth;           halfPeriod = noteE4;  end
        // Mid-song breath
        6'd22: begin duration = eighth;           halfPeriod = rest;    end
        // Second phrase
        6'd23: begin duration = eighth;           halfPeriod = noteD5;  end
        6'd24: begin duration = eighth;           halfPeriod = noteCs5; end
        6'd25: begin duration = tripletEighth;    halfPeriod = noteC5;  end
        6'd26: begin duration = tripletEighth;    halfPeriod = noteC5;  end
        6'd27: begin duration = tripletEighth;    halfPeriod = noteC5;  end
        6'd28: begin duration = eighth;           halfPeriod = noteB4;  end
        6'd29: begin duration = eighth;           halfPeriod = noteAs4; end
        6'd30: begin duration = sixteenth;        halfPeriod = noteA4;  end
        6'd31: begin duration = sixteenth;        halfPeriod = noteA4;  end
        6'd32: begin duration = sixteenth;        halfPeriod = rest;    end
        6'd33: begin duration = sixteenth;        halfPeriod = noteA4;  end
        6'd34: begin duration = eighth;           halfPeriod = noteG4;  end
        6'd35: begin duration = eighth;           halfPeriod = noteF4;  end
        6'd36: begin duration = tripletSixteenth; halfPeriod = noteE4;  end
        6'd37: begin duration = tripletSixteenth; halfPeriod = noteF4;  end
        6'd38: begin duration = tripletSixteenth; halfPeriod = noteE4;  end
        6'd39: begin duration = sixteenth;        halfPeriod = noteD4;  end
        6'd40: begin duration = sixteenth;        halfPeriod = noteE4;  end
        6'd41: begin duration = eighth;           halfPeriod = noteF4;  end
        6'd42: begin duration = eighth;           halfPeriod = noteE4;  end
        // Final held note
        6'd43: begin duration = quarter;          halfPeriod = noteD4;  end
        default: begin
          duration   = noDur;
          halfPeriod = rest;
        end
      endcase
    end
  end

endmodule

//--- source/soundFxPkg.sv
package soundFxPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths with a meaning
  ////////////////////////////////////////////////////////////////////////////

  // Note index, 0 is idle and 1..songLength are notes
  typedef logic [5:0] noteIdxT;

  // Tone half-period in clock ticks, zero marks a rest
  typedef logic [17:0] halfPeriodT;

  // Note length in 1/48 whole-note units
  typedef logic [3:0] noteUnitsT;

  // Duration codes as stored in the song bank
  typedef enum logic [2:0] {
    noDur            = 3'd0,
    quarter          = 3'd1,
    eighth           = 3'd2,
    tripletEighth    = 3'd3,
    sixteenth        = 3'd4,
    tripletSixteenth = 3'd5
  } durationT;

  // Sequencer states
  typedef enum logic [1:0] {
    idle,
    playNote,
    finish
  } seqStateT;

  // Last valid note index
  localparam noteIdxT songLength = 6'd43;

  // Duration code to 1/48 units
  function automatic noteUnitsT durationUnits(input durationT dur);
    case (dur)
      quarter:          return 4'd12;
      eighth:           return 4'd6;
      tripletEighth:    return 4'd4;
      sixteenth:        return 4'd3;
      tripletSixteenth: return 4'd2;
      default:          return 4'd0;
    endcase
  endfunction

endpackage

//--- source/soundFxPlayer.sv
`timescale 1ns/1ns

module soundFxPlayer import soundFxPkg::*; #(
  parameter int unitTicks = 104166,
  parameter int toneShift = 0
) (
  input  logic     clk,
  input  logic     rstN,
  input  logic     start,
  input  logic     stop,
  input  logic     loop,
  output logic     tone,
  output logic     playing,
  output noteIdxT  noteIndex,
  output durationT duration,
  output logic     songDone
);

  // Internal strobes and ROM data
  logic       noteLoad;
  logic       noteEnd;
  halfPeriodT halfPeriod;

  // Start, stop, loop and index stepping
  noteSequencer noteSequencer_inst (
    .clk       (clk),
    .rstN      (rstN),
    .start     (start),
    .stop      (stop),
    .loop      (loop),
    .noteEnd   (noteEnd),
    .noteIndex (noteIndex),
    .playing   (playing),
    .noteLoad  (noteLoad),
    .songDone  (songDone)
  );

  // Melody lookup
  songRom songRom_inst (
    .noteIndex  (noteIndex),
    .duration   (duration),
    .halfPeriod (halfPeriod)
  );

  // Note length
  durationTimer #(
    .unitTicks (unitTicks)
  ) durationTimer_inst (
    .clk      (clk),
    .rstN     (rstN),
    .noteLoad (noteLoad),
    .duration (duration),
    .noteEnd  (noteEnd)
  );

  // Square wave out
  toneGenerator #(
    .toneShift (toneShift)
  ) toneGenerator_inst (
    .clk        (clk),
    .rstN       (rstN),
    .noteLoad   (noteLoad),
    .playing    (playing),
    .halfPeriod (halfPeriod),
    .tone       (tone)
  );

endmodule

//--- source/toneGenerator.sv
`timescale 1ns/1ns

module toneGenerator import soundFxPkg::*; #(
  parameter int toneShift = 0
) (
  input  logic       clk,
  input  logic       rstN,
  input  logic       noteLoad,
  input  logic       playing,
  input  halfPeriodT halfPeriod,
  output logic       tone
);

  halfPeriodT effHalf;
  halfPeriodT cnt;
  halfPeriodT cntNow;
  logic       toneQ;
  logic       toneNow;

  // Scaled half-period for slower clocks
  assign effHalf = halfPeriod >> toneShift;

  // New note starts from a clean phase
  assign cntNow  = noteLoad ? '0 : cnt;
  assign toneNow = noteLoad ? 1'b0 : toneQ;

  ////////////////////////////////////////////////////////////////////////////
  // Half-period counter
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      cnt   <= '0;
      toneQ <= 1'b0;
    end else if (!playing || effHalf == '0) begin
      // Rest or stopped
      cnt   <= '0;
      toneQ <= 1'b0;
    end else if (cntNow == effHalf - 1'b1) begin
      // Flip on wrap
      cnt   <= '0;
      toneQ <= !toneNow;
    end else begin
      cnt   <= cntNow + 1'b1;
      toneQ <= toneNow;
    end
  end

  // Low on the load cycle and whenever the player is off
  assign tone = toneQ && playing && !noteLoad;

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Output silent whenever the player is off
  toneSilentWhenIdle: assert property (@(posedge clk) disable iff (!rstN)
    !playing |-> !tone);

endmodule
